/* common/mem_cache_config.svh */
/*
 * Instruction cache geometry: 4 ways, 32 sets, 32-byte lines
 * Set and offset bits lie inside the 12-bit page offset
 * Tag is the 17-bit physical page plus ppo[11:10]
 * Values are fixed; changing one means checking every width
 */
`ifndef MEM_CACHE_CONFIG_SVH
`define MEM_CACHE_CONFIG_SVH

// Associativity
`define MEM_IC_WAYS       4
`define MEM_IC_WAY_BITS   2
`define MEM_IC_LRU_BITS   3 // Tree bits per set

// Sets
`define MEM_IC_SETS       32
`define MEM_IC_SET_BITS   5
`define MEM_IC_SET_HI     9 // Set field in ppo
`define MEM_IC_SET_LO     5

// Tag and line
`define MEM_IC_TAG_BITS   19
`define MEM_IC_PPO_TAG_HI 11 // Low tag bits taken from ppo
`define MEM_IC_PPO_TAG_LO 10
`define MEM_IC_HALF_BIT   4 // Offset bit picking the line half
`define MEM_IC_LINE_BITS  256
`define MEM_IC_BEAT_BITS  128
`define MEM_IC_BEATS      2 // Refill beats per line

`endif

/* common/mem_cache_pkg.sv */
/*
 * Core-side and array types of the instruction cache
 * Widths come from the geometry header
 * Control states are shared by the FSM and nothing else
 */
`include "mem_cache_config.svh"

package mem_cache_pkg;

	// Address fields
	typedef logic [`MEM_IC_TAG_BITS-1:0] ic_tag_t; // Physical tag, paddr[28:10]
	typedef logic [`MEM_IC_SET_BITS-1:0] ic_set_t; // Set index, ppo[9:5]
	typedef logic [`MEM_IC_WAY_BITS-1:0] ic_way_t; // Way number
	typedef logic ic_half_t; // Line half, ppo[4]

	// Array results
	typedef logic [`MEM_IC_WAYS-1:0] ic_hit_t; // One-hot hit per way
	typedef logic [`MEM_IC_BEAT_BITS-1:0] ic_beat_t; // Fetch word to core

	// Decoded request address, registered at request start
	typedef struct packed {
		ic_tag_t  tag;  // Compared against tag array
		ic_set_t  set;  // Row of all arrays
		ic_half_t half; // Which 128-bit half returns
	} ic_lookup_t;

	// Control FSM
	typedef enum logic [2:0] {
		IDLE,       // Waiting for request
		LOOKUP,     // Array read in flight
		FILL_REQ,   // Line requested, no beat yet
		FILL_BEAT1, // Lower half in, waiting upper
		REPLAY,     // Tag install, last beat write
		DONE        // Read results visible
	} ic_state_t;

endpackage

/* common/mem_fill_pkg.sv */
/*
 * Refill path types towards next-level memory
 * A line arrives as two 128-bit beats, lower half first
 * Way and set reuse the cache package types
 */
`include "mem_cache_config.svh"

package mem_fill_pkg;

	// Line address, paddr[28:5]
	typedef logic [`MEM_IC_TAG_BITS+`MEM_IC_SET_BITS-1:0] fill_addr_t;

	// One refill beat
	typedef logic [`MEM_IC_BEAT_BITS-1:0] fill_beat_t;

	// Beat write into the data array
	typedef struct packed {
		mem_cache_pkg::ic_way_t          way;  // Victim way
		mem_cache_pkg::ic_set_t          set;  // Target row
		logic [$clog2(`MEM_IC_BEATS)-1:0] beat; // 0 lower, 1 upper
		fill_beat_t                      data; // Beat payload
	} fill_wr_t;

endpackage

/* icache/icache_ctrl.sv */
/*
 * Instruction cache control FSM
 * Hit: ready 2 cycles after request is sampled
 * Miss: two-beat refill into the victim, then a replay read
 * Core must hold req and address until the ready pulse
 */
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                      clkrst_mem_clk,
	input  logic                      rst_n,
	input  logic                      mem_inst_req, // Core request level
	input  mem_cache_pkg::ic_lookup_t core_addr,    // Decoded core address
	input  mem_cache_pkg::ic_hit_t    hit,          // From tag array
	input  mem_cache_pkg::ic_way_t    victim,       // From tag array
	input  logic                      fill_valid,   // Beat strobe
	input  mem_fill_pkg::fill_beat_t  fill_data,
	output mem_cache_pkg::ic_lookup_t look,         // Held request address
	output logic                      rd_stb,
	output logic                      tag_wr_stb,
	output mem_cache_pkg::ic_way_t    tag_wr_way,
	output mem_fill_pkg::fill_wr_t    data_wr,
	output logic                      data_wr_stb,
	output logic                      mem_inst_rdy,
	output logic                      fill_req,
	output mem_fill_pkg::fill_addr_t  fill_addr
);

	mem_cache_pkg::ic_state_t state_q;
	mem_cache_pkg::ic_state_t state_d;
	mem_cache_pkg::ic_way_t   fill_way_q; // Victim latched on miss
	logic                     any_hit;
	logic                     beat_take; // Beat accepted this cycle

	assign any_hit = |hit;
	assign beat_take = fill_valid &&
		(state_q == mem_cache_pkg::FILL_REQ || state_q == mem_cache_pkg::FILL_BEAT1);

	// Strobes decoded from state
	assign rd_stb       = (state_q == mem_cache_pkg::LOOKUP);
	assign tag_wr_stb   = (state_q == mem_cache_pkg::REPLAY); // Install with last beat
	assign tag_wr_way   = fill_way_q;
	assign mem_inst_rdy = (state_q == mem_cache_pkg::DONE) && any_hit;

	// Level from the miss cycle until first beat
	assign fill_req = (state_q == mem_cache_pkg::FILL_REQ) ||
		((state_q == mem_cache_pkg::DONE) && !any_hit);
	assign fill_addr = mem_fill_pkg::fill_addr_t'({look.tag, look.set}); // Line address

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_cache_pkg::IDLE:       if (mem_inst_req) state_d = mem_cache_pkg::LOOKUP;
			mem_cache_pkg::LOOKUP:     state_d = mem_cache_pkg::DONE;
			mem_cache_pkg::DONE:       state_d = any_hit ? mem_cache_pkg::IDLE
			                                             : mem_cache_pkg::FILL_REQ;
			mem_cache_pkg::FILL_REQ:   if (fill_valid) state_d = mem_cache_pkg::FILL_BEAT1;
			mem_cache_pkg::FILL_BEAT1: if (fill_valid) state_d = mem_cache_pkg::REPLAY;
			mem_cache_pkg::REPLAY:     state_d = mem_cache_pkg::LOOKUP; // Reread from array
			default:                   state_d = mem_cache_pkg::IDLE;
		endcase
	end

	// Control state
	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n) begin
			state_q     <= mem_cache_pkg::IDLE;
			data_wr_stb <= 1'b0;
		end else begin
			state_q     <= state_d;
			data_wr_stb <= beat_take; // Write one cycle after arrival
		end
	end

	// Address, victim and beat payload
	always_ff @(posedge clkrst_mem_clk) begin
		if (state_q == mem_cache_pkg::IDLE && mem_inst_req)
			look <= core_addr; // Held for the whole request
		if (state_q == mem_cache_pkg::DONE && !any_hit)
			fill_way_q <= victim;
		if (beat_take) begin
			data_wr.way  <= fill_way_q;
			data_wr.set  <= look.set;
			data_wr.beat <= (state_q == mem_cache_pkg::FILL_BEAT1); // Upper half second
			data_wr.data <= fill_data;
		end
	end

endmodule

/* icache/icache_tags.sv */
/*
 * Tag and valid arrays with per-way compare
 * Victim is lowest invalid way, else tree pseudo-LRU
 * Hit and victim are registered one cycle after rd_stb
 */
`timescale 1ns/1ps

module icache_tags (
	input  logic                      clkrst_mem_clk,
	input  logic                      rst_n,
	input  logic                      rd_stb,     // Lookup strobe
	input  mem_cache_pkg::ic_lookup_t look,       // Tag and set in use
	input  logic                      tag_wr_stb, // Install strobe
	input  mem_cache_pkg::ic_way_t    tag_wr_way,
	output mem_cache_pkg::ic_hit_t    hit,
	output mem_cache_pkg::ic_way_t    victim
);

	mem_cache_pkg::ic_tag_t      tag_mem [`MEM_IC_WAYS][`MEM_IC_SETS];
	logic [`MEM_IC_WAYS-1:0]     valid_q [`MEM_IC_SETS];
	logic [`MEM_IC_LRU_BITS-1:0] lru_q [`MEM_IC_SETS]; // [0] root, [1] ways 0/1, [2] ways 2/3
	logic [`MEM_IC_LRU_BITS-1:0] lru_cur;
	logic [`MEM_IC_LRU_BITS-1:0] lru_next;
	mem_cache_pkg::ic_hit_t      hit_c;
	mem_cache_pkg::ic_way_t      hit_way;
	mem_cache_pkg::ic_way_t      victim_c;
	mem_cache_pkg::ic_way_t      upd_way;
	logic                        upd_en;

	// Compare all ways of the set
	always_comb begin
		hit_c   = '0;
		hit_way = '0;
		for (int w = 0; w < `MEM_IC_WAYS; w++) begin
			hit_c[w] = valid_q[look.set][w] && (tag_mem[w][look.set] == look.tag);
			if (hit_c[w])
				hit_way = mem_cache_pkg::ic_way_t'(w); // One-hot encode
		end
	end

	// Victim choice
	always_comb begin
		lru_cur  = lru_q[look.set];
		victim_c = {lru_cur[0], lru_cur[0] ? lru_cur[2] : lru_cur[1]}; // Root picks pair
		for (int w = `MEM_IC_WAYS - 1; w >= 0; w--)
			if (!valid_q[look.set][w])
				victim_c = mem_cache_pkg::ic_way_t'(w); // Lowest invalid wins
	end

	// Tree update points away from the used way
	assign upd_en  = tag_wr_stb || (rd_stb && |hit_c);
	assign upd_way = tag_wr_stb ? tag_wr_way : hit_way;

	always_comb begin
		lru_next    = lru_cur;
		lru_next[0] = ~upd_way[1];
		if (upd_way[1])
			lru_next[2] = ~upd_way[0];
		else
			lru_next[1] = ~upd_way[0];
	end

	// Valid, LRU and read results
	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n) begin
			for (int s = 0; s < `MEM_IC_SETS; s++) begin
				valid_q[s] <= '0;
				lru_q[s]   <= '0;
			end
			hit    <= '0;
			victim <= '0;
		end else begin
			if (tag_wr_stb)
				valid_q[look.set][tag_wr_way] <= 1'b1;
			if (upd_en)
				lru_q[look.set] <= lru_next;
			if (rd_stb) begin
				hit    <= hit_c;
				victim <= victim_c;
			end
		end
	end

	// Tag storage
	always_ff @(posedge clkrst_mem_clk) begin
		if (tag_wr_stb)
			tag_mem[tag_wr_way][look.set] <= look.tag;
	end

endmodule

/* icache/icache_data.sv */
/*
 * Line storage, one 256-bit line per way and set
 * Writes one 128-bit beat per strobe
 * Reads the selected half of every way, output muxed by one-hot hit
 * Output is zero when no way hits
 */
`timescale 1ns/1ps

module icache_data (
	input  logic                      clkrst_mem_clk,
	input  logic                      rd_stb,      // Lookup strobe
	input  mem_cache_pkg::ic_lookup_t look,        // Set and half to read
	input  mem_cache_pkg::ic_hit_t    hit,         // Registered, aligned with half_q
	input  logic                      data_wr_stb, // Beat write strobe
	input  mem_fill_pkg::fill_wr_t    data_wr,
	output mem_cache_pkg::ic_beat_t   mem_inst_mdr
);

	logic [`MEM_IC_LINE_BITS-1:0] line_mem [`MEM_IC_WAYS][`MEM_IC_SETS];
	mem_cache_pkg::ic_beat_t      half_q [`MEM_IC_WAYS]; // Per-way read register

	// Beat write and read of all ways
	always_ff @(posedge clkrst_mem_clk) begin
		if (data_wr_stb)
			line_mem[data_wr.way][data_wr.set][data_wr.beat * `MEM_IC_BEAT_BITS +:
				`MEM_IC_BEAT_BITS] <= data_wr.data;
		if (rd_stb) begin
			for (int w = 0; w < `MEM_IC_WAYS; w++)
				half_q[w] <= line_mem[w][look.set][look.half * `MEM_IC_BEAT_BITS +:
					`MEM_IC_BEAT_BITS];
		end
	end

	// Way select
	always_comb begin
		mem_inst_mdr = '0;
		for (int w = 0; w < `MEM_IC_WAYS; w++)
			if (hit[w])
				mem_inst_mdr = mem_inst_mdr | half_q[w]; // At most one way set
	end

endmodule

/* icache/mem_inst_loc.sv */
/*
 * Level-one instruction cache, 4-way, 32 sets, 32-byte lines
 * Set from ppo[9:5], tag is {ppg, ppo[11:10]}, half from ppo[4]
 * Core holds req and address until the one-cycle rdy pulse
 * Refill takes two 128-bit beats, lower half first, no back-pressure
 */
`timescale 1ns/1ps

module mem_inst_loc (
	input  logic                     clkrst_mem_clk,
	input  logic                     rst_n,
	input  logic                     mem_inst_req, // Request level from core
	input  logic [16:0]              mem_inst_ppg, // Physical page
	input  logic [11:0]              mem_inst_ppo, // Page offset
	input  logic                     fill_valid,   // Refill beat strobe
	input  mem_fill_pkg::fill_beat_t fill_data,
	output mem_cache_pkg::ic_beat_t  mem_inst_mdr, // Fetch word, valid with rdy
	output logic                     mem_inst_rdy, // One-cycle done pulse
	output logic                     fill_req,     // Held until first beat
	output mem_fill_pkg::fill_addr_t fill_addr
);

	mem_cache_pkg::ic_lookup_t core_addr;
	mem_cache_pkg::ic_lookup_t look;
	mem_cache_pkg::ic_hit_t    hit;
	mem_cache_pkg::ic_way_t    victim;
	mem_cache_pkg::ic_way_t    tag_wr_way;
	mem_fill_pkg::fill_wr_t    data_wr;
	logic                      rd_stb;
	logic                      tag_wr_stb;
	logic                      data_wr_stb;

	// Address decode
	assign core_addr.tag  = {mem_inst_ppg, mem_inst_ppo[`MEM_IC_PPO_TAG_HI:`MEM_IC_PPO_TAG_LO]};
	assign core_addr.set  = mem_inst_ppo[`MEM_IC_SET_HI:`MEM_IC_SET_LO];
	assign core_addr.half = mem_inst_ppo[`MEM_IC_HALF_BIT];

	icache_ctrl u_ctrl (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.mem_inst_req   (mem_inst_req),
		.core_addr      (core_addr),
		.hit            (hit),
		.victim         (victim),
		.fill_valid     (fill_valid),
		.fill_data      (fill_data),
		.look           (look),
		.rd_stb         (rd_stb),
		.tag_wr_stb     (tag_wr_stb),
		.tag_wr_way     (tag_wr_way),
		.data_wr        (data_wr),
		.data_wr_stb    (data_wr_stb),
		.mem_inst_rdy   (mem_inst_rdy),
		.fill_req       (fill_req),
		.fill_addr      (fill_addr)
	);

	icache_tags u_tags (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.rd_stb         (rd_stb),
		.look           (look),
		.tag_wr_stb     (tag_wr_stb),
		.tag_wr_way     (tag_wr_way),
		.hit            (hit),
		.victim         (victim)
	);

	icache_data u_data (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rd_stb         (rd_stb),
		.look           (look),
		.hit            (hit),
		.data_wr_stb    (data_wr_stb),
		.data_wr        (data_wr),
		.mem_inst_mdr   (mem_inst_mdr)
	);

endmodule

/* dv/tb_clkgen.sv */
/*
 * Testbench clock source
 * Free-running, 40 ns period, starts low
 */
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk // Drives the DUT and the memory model
);

	localparam time HALF_PERIOD = 20ns; // 40 ns period

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

/* dv/fill_mem_model.sv */
/*
 * Next-level memory model for the refill port
 * Every 32-bit word equals its byte address xor 32'h5a5a0000
 * Lower beat first, each after a random gap of 1 to 6 cycles
 * Samples fill_req at the falling edge, drives on the rising edge
 */
`timescale 1ns/1ps

module fill_mem_model (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     fill_req,   // Line request level
	input  mem_fill_pkg::fill_addr_t fill_addr,  // paddr[28:5]
	output logic                     fill_valid, // One pulse per beat
	output mem_fill_pkg::fill_beat_t fill_data
);

	integer                   seed;      // Gap generator state
	mem_fill_pkg::fill_addr_t line_addr; // Captured with the request
	int                       gap;

	// Beat contents from the memory rule
	function automatic mem_fill_pkg::fill_beat_t beat_of(input mem_fill_pkg::fill_addr_t addr,
		input logic upper);
		logic [31:0]              base;
		mem_fill_pkg::fill_beat_t beat;
		base = {3'b000, addr, upper, 4'h0}; // Byte address of word 0
		for (int i = 0; i < 4; i++)
			beat[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h5a5a0000; // Word 0 in low bits
		return beat;
	endfunction

	// One beat after a random gap
	task automatic send_beat(input logic upper);
		gap = 1 + ({$random(seed)} % 6); // 1 to 6 cycles
		repeat (gap) @(posedge clk);
		fill_valid <= 1'b1;
		fill_data  <= beat_of(line_addr, upper);
		@(posedge clk);
		fill_valid <= 1'b0; // Single-cycle pulse
	endtask

	initial begin
		seed       = 32'h97eadfed;
		fill_valid = 1'b0;
		fill_data  = '0;
		forever begin
			@(negedge clk); // Request level is stable here
			if (rst_n && fill_req) begin
				line_addr = fill_addr;
				send_beat(1'b0); // Lower half
				send_beat(1'b1); // Upper half
			end
		end
	end

endmodule

/* dv/mem_inst_loc_tb.sv */
/*
 * Testbench for the instruction cache top level
 * Expected words follow the memory rule, byte address xor 32'h5a5a0000
 * A reference table of tags, valid bits and tree LRU predicts hit or miss
 * Requests start on a rising edge, outputs are sampled at the falling edge
 * Each wait for ready is bounded by 200 cycles
 */
`timescale 1ns/1ps

module mem_inst_loc_tb;

	localparam int TIMEOUT = 200; // Cycles per wait for ready

	logic                     clk;
	logic                     rst_n;
	logic                     mem_inst_req;
	logic [16:0]              mem_inst_ppg;
	logic [11:0]              mem_inst_ppo;
	logic                     fill_valid;
	mem_fill_pkg::fill_beat_t fill_data;
	mem_cache_pkg::ic_beat_t  mem_inst_mdr;
	logic                     mem_inst_rdy;
	logic                     fill_req;
	mem_fill_pkg::fill_addr_t fill_addr;

	logic [18:0] ref_tag [32][4]; // Model tags per set and way
	logic [3:0]  ref_valid [32];
	logic [2:0]  ref_lru [32];    // [0] root, [1] ways 0/1, [2] ways 2/3
	int          errors;
	int          checks;
	integer      seed;            // Random request stream
	logic        timed_out;       // A ready wait ran out

	tb_clkgen u_clkgen (.clk(clk));

	fill_mem_model u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.fill_req   (fill_req),
		.fill_addr  (fill_addr),
		.fill_valid (fill_valid),
		.fill_data  (fill_data)
	);

	mem_inst_loc u_dut (
		.clkrst_mem_clk (clk),
		.rst_n          (rst_n),
		.mem_inst_req   (mem_inst_req),
		.mem_inst_ppg   (mem_inst_ppg),
		.mem_inst_ppo   (mem_inst_ppo),
		.fill_valid     (fill_valid),
		.fill_data      (fill_data),
		.mem_inst_mdr   (mem_inst_mdr),
		.mem_inst_rdy   (mem_inst_rdy),
		.fill_req       (fill_req),
		.fill_addr      (fill_addr)
	);

	// Requested half from the memory rule
	function automatic mem_cache_pkg::ic_beat_t expect_word(input logic [16:0] ppg,
		input logic [11:0] ppo);
		logic [31:0]             base;
		mem_cache_pkg::ic_beat_t word;
		base = {3'b000, ppg, ppo[11:4], 4'h0}; // First byte of the half
		for (int i = 0; i < 4; i++)
			word[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h5a5a0000;
		return word;
	endfunction

	// Model lookup, install on miss, LRU touch
	task automatic predict_access(input logic [18:0] tag, input logic [4:0] set,
		output logic hit);
		logic [1:0] way;
		hit = 1'b0;
		way = 2'd0;
		for (int w = 0; w < 4; w++) begin
			if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
				hit = 1'b1;
				way = 2'(w);
			end
		end
		if (!hit) begin
			way = ref_lru[set][0] ? {1'b1, ref_lru[set][2]} : {1'b0, ref_lru[set][1]};
			for (int w = 3; w >= 0; w--) begin
				if (!ref_valid[set][w])
					way = 2'(w); // Lowest empty way first
			end
			ref_tag[set][way]   = tag;
			ref_valid[set][way] = 1'b1;
		end
		ref_lru[set][0] = ~way[1]; // Point away from the used way
		if (way[1])
			ref_lru[set][2] = ~way[0];
		else
			ref_lru[set][1] = ~way[0];
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (!timed_out) begin
			checks++;
			assert (got === exp) else begin
				errors++;
				$display("Mismatch %s: got %0h expected %0h", name, got, exp);
			end
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	// One core request, checked against the model
	task automatic fetch_check(input logic [16:0] ppg, input logic [11:0] ppo,
		output mem_cache_pkg::ic_beat_t word, output logic miss);
		logic pred_hit;
		logic done;
		int   lat;
		miss = 1'b0;
		word = '0;
		if (!timed_out) begin
			predict_access({ppg, ppo[11:10]}, ppo[9:5], pred_hit);
			done = 1'b0;
			lat  = 0;
			@(posedge clk);
			mem_inst_req <= 1'b1;
			mem_inst_ppg <= ppg;
			mem_inst_ppo <= ppo;
			@(posedge clk); // DUT samples the request here
			while (!done && lat < TIMEOUT) begin
				@(negedge clk);
				lat++;
				if (fill_req && !miss) begin
					check_value("fill_addr", fill_addr, {ppg, ppo[11:5]}); // First cycle only
					miss = 1'b1;
				end
				done = mem_inst_rdy;
			end
			if (!done) begin
				errors++;
				timed_out = 1'b1;
				$display("Timeout: no ready pulse within %0d cycles for ppg %h ppo %h",
					TIMEOUT, ppg, ppo);
			end else begin
				word = mem_inst_mdr;
				check_value("mem_inst_mdr", mem_inst_mdr, expect_word(ppg, ppo));
				check_value("fill_req", miss, !pred_hit); // Seen fill_req against model
				if (pred_hit)
					check_value("mem_inst_rdy latency", lat, 2);
			end
			@(posedge clk);
			mem_inst_req <= 1'b0; // Drop after the pulse
		end
	endtask

	// Access in the shared eviction set 7
	task automatic evict_step(input logic [16:0] ppg, input logic exp_miss);
		mem_cache_pkg::ic_beat_t word;
		logic                    miss;
		fetch_check(ppg, 12'h0e0, word, miss);
		check_value("fill_req", miss, exp_miss);
	endtask

	// Ready only answers a pending request
	always @(negedge clk) begin
		if (rst_n && mem_inst_rdy) begin
			assert (mem_inst_req) else begin
				errors++;
				$display("Ready pulse seen with no request pending");
			end
		end
	end

	initial begin
		mem_cache_pkg::ic_beat_t lo_word;
		mem_cache_pkg::ic_beat_t hi_word;
		logic                    miss;
		logic [31:0]             r;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		seed      = 32'h97eadfed;
		for (int s = 0; s < 32; s++) begin
			ref_valid[s] = '0;
			ref_lru[s]   = '0;
		end
		rst_n        <= 1'b0;
		mem_inst_req <= 1'b0;
		mem_inst_ppg <= '0;
		mem_inst_ppo <= '0;
		repeat (8) @(posedge clk); // Reset for 8 cycles
		rst_n <= 1'b1;

		repeat (4) begin // Quiet outputs before any request
			@(negedge clk);
			check_value("mem_inst_rdy", mem_inst_rdy, 1'b0);
			check_value("fill_req", fill_req, 1'b0);
		end

		fetch_check(17'h00abc, 12'h010, hi_word, miss); // Cold miss, upper half
		check_value("fill_req", miss, 1'b1);
		fetch_check(17'h00abc, 12'h010, hi_word, miss); // Same address hits
		check_value("fill_req", miss, 1'b0);
		fetch_check(17'h00abc, 12'h004, lo_word, miss); // Lower half, same line
		check_value("fill_req", miss, 1'b0);
		if (!timed_out) begin
			checks++;
			assert (lo_word !== hi_word) else begin
				errors++;
				$display("Both halves of one line returned the same word");
			end
		end

		evict_step(17'h00100, 1'b1); // A
		evict_step(17'h00200, 1'b1); // B
		evict_step(17'h00300, 1'b1); // C
		evict_step(17'h00400, 1'b1); // D
		evict_step(17'h00100, 1'b0); // A hits
		evict_step(17'h00500, 1'b1); // E takes C's way
		evict_step(17'h00100, 1'b0); // A survives
		evict_step(17'h00300, 1'b1); // C was evicted

		repeat (300) begin // 8 tags over sets 2 and 3
			r = $random(seed);
			fetch_check({15'h0400, r[1:0]}, {1'b0, r[2], 4'b0001, r[3], r[4], r[8:5]},
				lo_word, miss);
		end

		finish_run();
	end

endmodule

/* filelist.f */
+incdir+common
common/mem_cache_pkg.sv
common/mem_fill_pkg.sv
icache/icache_ctrl.sv
icache/icache_tags.sv
icache/icache_data.sv
icache/mem_inst_loc.sv
dv/tb_clkgen.sv
dv/fill_mem_model.sv
dv/mem_inst_loc_tb.sv

/* Bender.yml */
package:
  name: mem_inst_loc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_cache_pkg.sv
      - common/mem_fill_pkg.sv
      - icache/icache_ctrl.sv
      - icache/icache_tags.sv
      - icache/icache_data.sv
      - icache/mem_inst_loc.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_clkgen.sv
      - dv/fill_mem_model.sv
      - dv/mem_inst_loc_tb.sv
